// File: hdl/memsys_macros.svh
// address map and bus sizes shared by RTL and testbench
// RAM window is MEM_WORDS words from MEM_BASE, word aligned only
`ifndef MEMSYS_MACROS_SVH
`define MEMSYS_MACROS_SVH

`define MEM_BASE      32'h8000_0000
`define MEM_WORDS     256
`define MEM_IDX_W     $clog2(`MEM_WORDS)
`define MMIO_IRQ_ADDR 32'h8380_0100

// bit 32 carries the capability tag
`define DATA_W        33
`define WAIT_W        4

`endif

// File: hdl/memsys_pkg.sv
// types for the data-bus responder and the interrupt generator
// irq source order is the rotation order and the irq_o bit index
package memsys_pkg;

  // one transaction outstanding at a time
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    GNT_WAIT  = 2'd1,
    RESP_WAIT = 2'd2,
    RESP      = 2'd3
  } resp_state_e;

  // external is irq bit 0, software bit 1, timer bit 2
  typedef enum logic [1:0] {
    EXTERNAL = 2'd0,
    SOFTWARE = 2'd1,
    TIMER    = 2'd2
  } irq_src_e;

endpackage

// File: hdl/dbus_if.sv
// single-port memory side of the data bus
// mem_en is a one-cycle strobe, read data is registered by the memory
`timescale 1ns/1ps
`include "memsys_macros.svh"

interface dbus_if;

  logic                  mem_en;
  logic                  mem_we;
  logic [3:0]            mem_be;
  logic [`MEM_IDX_W-1:0] mem_idx;
  logic [`DATA_W-1:0]    mem_wdata;
  logic [`DATA_W-1:0]    mem_rdata;

  modport responder (
    output mem_en, mem_we, mem_be, mem_idx, mem_wdata,
    input  mem_rdata
  );

  modport sram (
    input  mem_en, mem_we, mem_be, mem_idx, mem_wdata,
    output mem_rdata
  );

endinterface

// File: hdl/stall_gen.sv
// pseudo-random wait counter, count is LFSR mod (wmax_i+1)
// a zero count gives done_o in the load cycle, count k gives it k cycles later
`timescale 1ns/1ps
`include "memsys_macros.svh"

module stall_gen #(
  parameter logic [15:0] SEED = 16'hace1
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               load_i,
  input  logic [`WAIT_W-1:0] wmax_i,
  output logic               done_o
);

  logic [15:0]        lfsr_q;
  logic [15:0]        mod_full;
  logic [`WAIT_W:0]   range;
  logic [`WAIT_W-1:0] pick;
  logic [`WAIT_W-1:0] cnt_q;

  assign range    = {1'b0, wmax_i} + 1'b1;
  assign mod_full = lfsr_q % {{(15 - `WAIT_W){1'b0}}, range};
  assign pick     = mod_full[`WAIT_W-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_q <= SEED;
      cnt_q  <= '0;
    end else begin
      // x^16 + x^14 + x^13 + x^11 + 1
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      if (load_i) begin
        cnt_q <= (pick == '0) ? '0 : pick - 1'b1;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign done_o = load_i ? (pick == '0) : (cnt_q == '0);

endmodule

// File: hdl/dbus_responder.sv
// req/gnt/rvalid responder, one transfer outstanding, no response back-pressure
// requester holds req and payload until gnt; unmapped addresses give err_o
// MMIO write acks pending bits in wdata 2:0, MMIO read returns them
`timescale 1ns/1ps
`include "memsys_macros.svh"

module dbus_responder (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  logic               we_i,
  input  logic [3:0]         be_i,
  input  logic [31:0]        addr_i,
  input  logic [`DATA_W-1:0] wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output logic               err_o,
  output logic [`DATA_W-1:0] rdata_o,
  input  logic [`WAIT_W-1:0] gnt_wmax_i,
  input  logic [`WAIT_W-1:0] resp_wmax_i,
  dbus_if.responder          mem,
  input  logic [2:0]         pending_i,
  output logic               irq_ack_o,
  output logic [2:0]         irq_ack_mask_o
);

  import memsys_pkg::*;

  resp_state_e        state_q, state_d;
  logic               gnt_load, gnt_done;
  logic               resp_done;
  logic [31:0]        ram_off;
  logic               is_ram, is_mmio;
  logic               rsp_err_q, rsp_ram_q;
  logic [`DATA_W-1:0] rsp_data_q;

  assign ram_off = addr_i - `MEM_BASE;
  assign is_ram  = ram_off < 32'(`MEM_WORDS * 4);
  assign is_mmio = (addr_i & ~32'h3) == `MMIO_IRQ_ADDR;

  // grant wait starts when a request is seen in IDLE
  assign gnt_load = (state_q == IDLE) & req_i;
  assign gnt_o    = req_i & gnt_done & ((state_q == IDLE) | (state_q == GNT_WAIT));

  stall_gen #(.SEED(16'hace1)) u_gnt_stall (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .load_i  (gnt_load),
    .wmax_i  (gnt_wmax_i),
    .done_o  (gnt_done)
  );

  // response wait loads at the accepting cycle
  stall_gen #(.SEED(16'h5a3c)) u_resp_stall (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .load_i  (gnt_o),
    .wmax_i  (resp_wmax_i),
    .done_o  (resp_done)
  );

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE, GNT_WAIT: begin
        if (gnt_o) begin
          state_d = resp_done ? RESP : RESP_WAIT;
        end else if (req_i) begin
          state_d = GNT_WAIT;
        end
      end
      RESP_WAIT: begin
        if (resp_done) begin
          state_d = RESP;
        end
      end
      RESP: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      rsp_err_q <= 1'b0;
      rsp_ram_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (gnt_o) begin
        rsp_err_q <= ~is_ram & ~is_mmio;
        rsp_ram_q <= is_ram & ~we_i;
      end
    end
  end

  // mmio read data sampled at the accepting edge
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rsp_data_q <= (is_mmio & ~we_i) ? {{(`DATA_W - 3){1'b0}}, pending_i} : '0;
    end
  end

  assign mem.mem_en    = gnt_o & is_ram;
  assign mem.mem_we    = we_i;
  assign mem.mem_be    = be_i;
  assign mem.mem_idx   = ram_off[`MEM_IDX_W+1:2];
  assign mem.mem_wdata = wdata_i;

  assign irq_ack_o      = gnt_o & is_mmio & we_i;
  assign irq_ack_mask_o = wdata_i[2:0];

  assign rvalid_o = (state_q == RESP);
  assign err_o    = rvalid_o & rsp_err_q;
  assign rdata_o  = rsp_ram_q ? mem.mem_rdata : rsp_data_q;

  // requester holds the request and its payload until the grant
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_i && !gnt_o |=> req_i && $stable({we_i, be_i, addr_i, wdata_i}));

  // an accepted transfer decodes a known address
  assert property (@(posedge clk_i) disable iff (reset_i)
    gnt_o |-> !$isunknown({we_i, addr_i}));

endmodule

// File: hdl/tagged_sram.sv
// word memory, byte enables on the 32 data bits
// tag bit is written only by a full-word write, any partial write clears it
// no reset, contents are unknown until written
`timescale 1ns/1ps
`include "memsys_macros.svh"

module tagged_sram (
  input  logic clk_i,
  dbus_if.sram mem
);

  logic [`DATA_W-1:0] mem_q [`MEM_WORDS];
  logic [`DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (mem.mem_en) begin
      if (mem.mem_we) begin
        for (int b = 0; b < 4; b++) begin
          if (mem.mem_be[b]) begin
            mem_q[mem.mem_idx][8*b +: 8] <= mem.mem_wdata[8*b +: 8];
          end
        end
        mem_q[mem.mem_idx][32] <= (&mem.mem_be) & mem.mem_wdata[32];
      end else begin
        rdata_q <= mem_q[mem.mem_idx];
      end
    end
  end

  // held until the next read strobe
  assign mem.mem_rdata = rdata_q;

endmodule

// File: hdl/intr_gen.sv
// interval interrupt source, rotates external, software, timer
// one pending bit set each time the counter reaches intvl_i
// pending bits are write-one-to-clear through ack_i and ack_mask_i
`timescale 1ns/1ps

module intr_gen (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       intr_en_i,
  input  logic [7:0] intvl_i,
  input  logic       ack_i,
  input  logic [2:0] ack_mask_i,
  output logic [2:0] pending_o
);

  import memsys_pkg::*;

  irq_src_e   src_q;
  logic [7:0] cnt_q;
  logic [2:0] pending_q;
  logic       fire;
  logic [2:0] set_mask;
  logic [2:0] clr_mask;

  assign fire     = intr_en_i & ~ack_i & (cnt_q == intvl_i);
  assign set_mask = fire ? (3'b001 << src_q) : 3'b000;
  assign clr_mask = ack_i ? ack_mask_i : 3'b000;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q     <= EXTERNAL;
      cnt_q     <= '0;
      pending_q <= '0;
    end else begin
      // set and clear never meet since an ack holds off the event
      pending_q <= (pending_q & ~clr_mask) | set_mask;
      if (!intr_en_i || ack_i || fire) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (fire) begin
        unique case (src_q)
          EXTERNAL: src_q <= SOFTWARE;
          SOFTWARE: src_q <= TIMER;
          default:  src_q <= EXTERNAL;
        endcase
      end
    end
  end

  assign pending_o = pending_q;

  assert property (@(posedge clk_i) disable iff (reset_i) !$isunknown(pending_o));

endmodule

// File: hdl/memsys_top.sv
// data-port memory harness: responder, tagged RAM and interval irq source
// irq_o is {timer, software, external}, cleared by MMIO writes to MMIO_IRQ_ADDR
`timescale 1ns/1ps
`include "memsys_macros.svh"

module memsys_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  logic               we_i,
  input  logic [3:0]         be_i,
  input  logic [31:0]        addr_i,
  input  logic [`DATA_W-1:0] wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output logic [`DATA_W-1:0] rdata_o,
  output logic               err_o,
  input  logic [`WAIT_W-1:0] gnt_wmax_i,
  input  logic [`WAIT_W-1:0] resp_wmax_i,
  input  logic [7:0]         intvl_i,
  input  logic               intr_en_i,
  output logic [2:0]         irq_o
);

  logic       irq_ack;
  logic [2:0] irq_ack_mask;
  logic [2:0] pending;

  dbus_if u_dbus ();

  dbus_responder u_responder (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .we_i           (we_i),
    .be_i           (be_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .gnt_o          (gnt_o),
    .rvalid_o       (rvalid_o),
    .err_o          (err_o),
    .rdata_o        (rdata_o),
    .gnt_wmax_i     (gnt_wmax_i),
    .resp_wmax_i    (resp_wmax_i),
    .mem            (u_dbus.responder),
    .pending_i      (pending),
    .irq_ack_o      (irq_ack),
    .irq_ack_mask_o (irq_ack_mask)
  );

  tagged_sram u_sram (
    .clk_i (clk_i),
    .mem   (u_dbus.sram)
  );

  intr_gen u_intr_gen (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .intr_en_i  (intr_en_i),
    .intvl_i    (intvl_i),
    .ack_i      (irq_ack),
    .ack_mask_i (irq_ack_mask),
    .pending_o  (pending)
  );

  assign irq_o = pending;

endmodule

// File: tests/memsys_checker.sv
// reference model of the memory harness, sampled on rising clock edges
// assumes word-aligned accesses and at most one outstanding transfer
`timescale 1ns/1ps
`include "memsys_macros.svh"

module memsys_checker (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  logic               we_i,
  input  logic [3:0]         be_i,
  input  logic [31:0]        addr_i,
  input  logic [`DATA_W-1:0] wdata_i,
  input  logic               gnt_i,
  input  logic               rvalid_i,
  input  logic [`DATA_W-1:0] rdata_i,
  input  logic               err_i,
  input  logic [`WAIT_W-1:0] gnt_wmax_i,
  input  logic [`WAIT_W-1:0] resp_wmax_i,
  input  logic [7:0]         intvl_i,
  input  logic               intr_en_i,
  input  logic [2:0]         irq_i,
  output int                 err_count_o,
  output int                 check_count_o
);

  logic [`DATA_W-1:0]    ref_mem [`MEM_WORDS];
  logic [`MEM_WORDS-1:0] written = '0;
  logic [`DATA_W-1:0]    exp_data;
  logic [2:0]            ref_pending;
  logic [7:0]            ref_cnt;
  logic                  busy;
  logic                  exp_err;
  logic                  exp_chk;
  int                    ref_src;
  int                    req_wait;
  int                    resp_wait;
  int                    resp_max;
  int                    errs = 0;
  int                    checks = 0;

  function automatic logic [`DATA_W-1:0] merge_bytes(input logic [`DATA_W-1:0] old_w,
                                                     input logic [`DATA_W-1:0] new_w,
                                                     input logic [3:0]         byte_en);
    logic [`DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (byte_en[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    // only a full-word write keeps the tag
    res[32] = (byte_en == 4'hf) & new_w[32];
    return res;
  endfunction

  task automatic compare(input string name, input logic [`DATA_W-1:0] got,
                         input logic [`DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("mismatch %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
    end
  endtask

  task automatic flag_error(input string what);
    errs++;
    $display("error at %0t: %s", $time, what);
  endtask

  always @(posedge clk_i) begin
    logic ack;
    logic fire;
    int   idx;
    if (reset_i) begin
      busy        = 1'b0;
      req_wait    = 0;
      ref_pending = '0;
      ref_cnt     = '0;
      ref_src     = 0;
    end else begin
      compare("irq_o", `DATA_W'(irq_i), `DATA_W'(ref_pending));
      if (busy) begin
        resp_wait++;
      end
      if (rvalid_i) begin
        if (!busy) begin
          flag_error("rvalid_o without an accepted transfer");
        end else begin
          if (resp_wait > resp_max) begin
            flag_error($sformatf("response after %0d cycles, limit %0d", resp_wait, resp_max));
          end
          compare("err_o", `DATA_W'(err_i), `DATA_W'(exp_err));
          if (exp_chk) begin
            compare("rdata_o", rdata_i, exp_data);
          end
        end
        busy = 1'b0;
      end

      ack = 1'b0;
      if (req_i && gnt_i) begin
        if (busy) begin
          flag_error("grant while a response is outstanding");
        end
        if (req_wait > int'(gnt_wmax_i)) begin
          flag_error($sformatf("grant after %0d wait cycles, limit %0d", req_wait, gnt_wmax_i));
        end
        busy      = 1'b1;
        resp_wait = 0;
        resp_max  = int'(resp_wmax_i) + 1;
        req_wait  = 0;
        exp_err   = 1'b0;
        exp_chk   = !we_i;
        exp_data  = '0;
        if (addr_i >= `MEM_BASE && addr_i < `MEM_BASE + `MEM_WORDS * 4) begin
          idx = int'((addr_i - `MEM_BASE) >> 2);
          if (we_i) begin
            ref_mem[idx] = merge_bytes(ref_mem[idx], wdata_i, be_i);
            written[idx] = 1'b1;
          end else if (!written[idx]) begin
            exp_chk = 1'b0;
            flag_error("read of a RAM word that was never written");
          end else begin
            exp_data = ref_mem[idx];
          end
        end else if (addr_i == `MMIO_IRQ_ADDR) begin
          ack      = we_i;
          exp_data = `DATA_W'(ref_pending);
        end else begin
          exp_err = 1'b1;
          exp_chk = 1'b1;
        end
      end else if (req_i) begin
        req_wait++;
      end

      // interval counter restarts when disabled and on every ack
      fire = 1'b0;
      if (!intr_en_i || ack) begin
        ref_cnt = '0;
      end else if (ref_cnt == intvl_i) begin
        fire    = 1'b1;
        ref_cnt = '0;
      end else begin
        ref_cnt = ref_cnt + 8'd1;
      end
      if (ack) begin
        ref_pending = ref_pending & ~wdata_i[2:0];
      end
      // external, software, timer, then around again
      if (fire) begin
        ref_pending = ref_pending | (3'b001 << ref_src);
        ref_src     = (ref_src + 1) % 3;
      end
    end
  end

  assign err_count_o   = errs;
  assign check_count_o = checks;

endmodule

// File: tests/tb_memsys.sv
// testbench top for the memory harness: clock, reset, pattern-driven requester
// pattern file path is relative to the project root, at most 64 operations
`timescale 1ns/1ps
`include "memsys_macros.svh"

module tb_memsys;

  localparam int MAX_OPS = 64;

  logic               clk;
  logic               reset;
  logic               req;
  logic               we;
  logic [3:0]         be;
  logic [31:0]        addr;
  logic [`DATA_W-1:0] wdata;
  logic               gnt;
  logic               rvalid;
  logic [`DATA_W-1:0] rdata;
  logic               err;
  logic [`WAIT_W-1:0] gnt_wmax;
  logic [`WAIT_W-1:0] resp_wmax;
  logic [7:0]         intvl;
  logic               intr_en;
  logic [2:0]         irq;
  logic               ops_loaded;
  logic [35:0]        pat_mem [0:4*MAX_OPS-1];
  int                 n_ops;
  int                 setup_errs;
  int                 err_count;
  int                 check_count;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  memsys_top u_dut (
    .clk_i (clk), .reset_i (reset), .req_i (req), .we_i (we), .be_i (be),
    .addr_i (addr), .wdata_i (wdata), .gnt_o (gnt), .rvalid_o (rvalid),
    .rdata_o (rdata), .err_o (err), .gnt_wmax_i (gnt_wmax), .resp_wmax_i (resp_wmax),
    .intvl_i (intvl), .intr_en_i (intr_en), .irq_o (irq)
  );

  memsys_checker u_checker (
    .clk_i (clk), .reset_i (reset), .req_i (req), .we_i (we), .be_i (be),
    .addr_i (addr), .wdata_i (wdata), .gnt_i (gnt), .rvalid_i (rvalid),
    .rdata_i (rdata), .err_i (err), .gnt_wmax_i (gnt_wmax), .resp_wmax_i (resp_wmax),
    .intvl_i (intvl), .intr_en_i (intr_en), .irq_i (irq),
    .err_count_o (err_count), .check_count_o (check_count)
  );

  task automatic set_config(input logic [35:0] gw, input logic [35:0] rw,
                            input logic [35:0] cfg);
    @(negedge clk);
    gnt_wmax  = gw[`WAIT_W-1:0];
    resp_wmax = rw[`WAIT_W-1:0];
    intvl     = cfg[7:0];
    intr_en   = cfg[8];
  endtask

  task automatic bus_transfer(input logic wr, input logic [31:0] adr,
                              input logic [3:0] byte_en, input logic [`DATA_W-1:0] data);
    int gap;
    gap = int'($urandom % 3);
    repeat (gap + 1) @(negedge clk);
    req   = 1'b1;
    we    = wr;
    be    = byte_en;
    addr  = adr;
    wdata = data;
    // hold the request until the grant edge
    @(posedge clk);
    while (!gnt) begin
      @(posedge clk);
    end
    @(negedge clk);
    req = 1'b0;
    we  = 1'b0;
    @(posedge clk);
    while (!rvalid) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_irq_bits(input logic [2:0] mask);
    @(posedge clk);
    while ((irq & mask) != mask) begin
      @(posedge clk);
    end
  endtask

  initial begin
    logic [3:0]  op;
    logic [35:0] arg_a;
    logic [35:0] arg_b;
    logic [35:0] arg_c;
    void'($urandom(97));
    reset      = 1'b1;
    req        = 1'b0;
    we         = 1'b0;
    be         = '0;
    addr       = '0;
    wdata      = '0;
    gnt_wmax   = '0;
    resp_wmax  = '0;
    intvl      = '0;
    intr_en    = 1'b0;
    ops_loaded = 1'b0;
    setup_errs = 0;
    // unread entries look like the end marker
    for (int i = 0; i < 4 * MAX_OPS; i++) begin
      pat_mem[i] = '1;
    end
    $readmemh("tests/memsys_patterns.txt", pat_mem);
    n_ops = 0;
    while (n_ops < MAX_OPS && pat_mem[4 * n_ops][3:0] != 4'hf) begin
      n_ops++;
    end
    ops_loaded = 1'b1;
    if (n_ops == 0) begin
      $display("no operations found in the pattern file");
      setup_errs++;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < n_ops; i++) begin
      op    = pat_mem[4 * i][3:0];
      arg_a = pat_mem[4 * i + 1];
      arg_b = pat_mem[4 * i + 2];
      arg_c = pat_mem[4 * i + 3];
      case (op)
        4'h0: set_config(arg_a, arg_b, arg_c);
        4'h1: bus_transfer(1'b1, arg_a[31:0], arg_b[3:0], arg_c[`DATA_W-1:0]);
        4'h2: bus_transfer(1'b0, arg_a[31:0], 4'hf, '0);
        4'h3: bus_transfer(1'b1, `MMIO_IRQ_ADDR, 4'hf, arg_c[`DATA_W-1:0]);
        4'h4: wait_irq_bits(arg_c[2:0]);
        default: begin
          $display("unknown operation %0h in pattern %0d", op, i);
          setup_errs++;
        end
      endcase
    end
    repeat (4) @(posedge clk);
    $display("patterns %0d, checks %0d, errors %0d", n_ops, check_count,
             err_count + setup_errs);
    if (err_count + setup_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // run length follows the number of operations
  initial begin
    wait (ops_loaded);
    repeat (n_ops * 64 + 200) @(posedge clk);
    $display("timeout: operations not finished after %0d cycles", n_ops * 64 + 200);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: tests/memsys_patterns.txt
// columns: op addr be data, op 0 config 1 write 2 read 3 ack 4 wait-irq f end
// config uses addr as grant wait max, be as response wait max, data as enable<<8 | interval
0 00000000 0 000000000
1 80000000 f 1deadbeef
2 80000000 0 000000000
0 00000003 4 000000000
1 80000004 f 012345678
1 80000004 3 1cafebabe
2 80000004 0 000000000
1 80000008 f 1a5a5a5a5
1 80000008 6 100ff0000
2 80000008 0 000000000
1 90000000 f 1ffffffff
2 90000000 0 000000000
1 800003fc f 111112222
2 800003fc 0 000000000
1 80000400 f 0bad0bad0
2 80000000 0 000000000
0 00000002 2 00000010f
4 00000000 0 000000007
2 83800100 0 000000000
3 00000000 0 000000005
2 83800100 0 000000000
0 00000005 3 000000000
3 00000000 0 000000007
2 83800100 0 000000000
f 00000000 0 000000000

// File: build.f
+incdir+hdl
hdl/memsys_pkg.sv
hdl/dbus_if.sv
hdl/stall_gen.sv
hdl/dbus_responder.sv
hdl/tagged_sram.sv
hdl/intr_gen.sv
hdl/memsys_top.sv
tests/memsys_checker.sv
tests/tb_memsys.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_memsys -Mdir obj_dir -o sim_memsys \
  && ./obj_dir/sim_memsys | tee sim.log \
  && grep -qx "TEST OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
